// File: project.f
src/stereo_types_pkg.sv
src/postproc_pipe_pkg.sv
src/pipe_delay.sv
src/subpixel_prep.sv
src/subpixel_divide.sv
src/uniqueness_check.sv
src/stereo_postprocess.sv
verif/tb_stereo_postprocess.sv

// File: Makefile
TOP = tb_stereo_postprocess

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Regression passed" sim.log

obj_dir/V$(TOP): project.f $(wildcard src/*.sv) $(wildcard verif/*.sv)
	verilator --binary --timing -f project.f --top-module $(TOP) -o V$(TOP)

lint:
	verilator --lint-only --timing -Wall -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: verif/tb_stereo_postprocess.sv
`default_nettype none

module tb_stereo_postprocess;

    localparam int LANES        = 2;
    localparam int SUB_BITS     = 4;
    localparam int L            = SUB_BITS + 4;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_HAND     = 14;
    localparam int NUM_RANDOM   = 100;
    localparam int NUM_ENTRIES  = NUM_HAND + NUM_RANDOM;
    localparam int TIMEOUT      = RESET_CYCLES + NUM_ENTRIES + L + 50;

    typedef struct packed {
        logic                                     valid;
        stereo_types_pkg::pix_in_t  [LANES-1:0]   px;
        stereo_types_pkg::pix_out_t [LANES-1:0]   exp;
    } entry_t;

    // expected beat with the cycle it has to show up in
    typedef struct packed {
        int                                       due;
        stereo_types_pkg::pix_out_t [LANES-1:0]   px;
    } exp_beat_t;

    logic                                   clk = 1'b0;
    logic                                   rst_n;
    logic                                   in_valid;
    stereo_types_pkg::pix_in_t  [LANES-1:0] pix_in;
    logic                                   out_valid;
    stereo_types_pkg::pix_out_t [LANES-1:0] pix_out;

    entry_t    tab [NUM_ENTRIES];
    exp_beat_t exp_q [$];
    int        cycle_cnt = 0;

    stereo_postprocess #(
        .MULT_R     (LANES),
        .SUB_BITS   (SUB_BITS),
        .UNIQUE_MUL (1),
        .UNIQUE_DIV (4)
    ) UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .pix_in    (pix_in),
        .out_valid (out_valid),
        .pix_out   (pix_out)
    );

    always #4 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_disp(input string name, input stereo_types_pkg::frac_disp_t got,
                              input stereo_types_pkg::frac_disp_t exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_sad(input string name, input stereo_types_pkg::sad_t got,
                             input stereo_types_pkg::sad_t exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    function automatic stereo_types_pkg::pix_in_t make_pix(input int disp, input int sad,
            input int lo, input int hi, input int thresh, input logic textured);
        stereo_types_pkg::pix_in_t p;
        p.disp     = stereo_types_pkg::disp_t'(disp);
        p.sad      = stereo_types_pkg::sad_t'(sad);
        p.lo       = stereo_types_pkg::sad_t'(lo);
        p.hi       = stereo_types_pkg::sad_t'(hi);
        p.thresh   = stereo_types_pkg::sad_t'(thresh);
        p.textured = textured;
        return p;
    endfunction

    // reference model: parabola offset in 1/16 pixel plus the 5/4 uniqueness margin
    function automatic stereo_types_pkg::pix_out_t expect_pixel(
            input stereo_types_pkg::pix_in_t p);
        int                         lo;
        int                         hi;
        int                         sad;
        int                         n;
        int                         d;
        int                         q;
        int                         fix;
        logic                       fail;
        stereo_types_pkg::pix_out_t r;
        lo  = int'(p.lo);
        hi  = int'(p.hi);
        sad = int'(p.sad);
        n   = (lo > hi) ? lo - hi : hi - lo;
        d   = 2 * (lo + hi - 2 * sad);
        if (lo < sad || hi < sad || d == 0) begin
            q = 0;
        end else begin
            q = (n * 16) / d;
            if (q > 8) begin
                q = 8;
            end
        end
        if (lo > hi) begin
            fix = int'(p.disp) * 16 + q;
        end else begin
            fix = int'(p.disp) * 16 - q;
        end
        if (fix < 0) begin
            fix = 0;
        end else if (fix > 1023) begin
            fix = 1023;
        end
        fail        = (int'(p.thresh) * 4) <= (sad * 5);
        r.frac_disp = stereo_types_pkg::frac_disp_t'(fix);
        r.sad       = p.sad;
        r.filtered  = p.textured | fail;
        return r;
    endfunction

    task automatic set_entry(input int idx, input logic valid,
                             input stereo_types_pkg::pix_in_t a,
                             input stereo_types_pkg::pix_in_t b);
        tab[idx].valid  = valid;
        tab[idx].px[0]  = a;
        tab[idx].px[1]  = b;
        tab[idx].exp[0] = expect_pixel(a);
        tab[idx].exp[1] = expect_pixel(b);
    endtask

    // lo and hi never below sad, thresh around the 5/4 margin
    function automatic stereo_types_pkg::pix_in_t random_pix();
        int sad;
        sad = int'($urandom % 40000);
        return make_pix(int'($urandom % 64), sad, sad + int'($urandom % 20000),
                        sad + int'($urandom % 20000), sad + int'($urandom % (sad / 2 + 1)),
                        ($urandom % 8) == 0);
    endfunction

    task automatic fill_table();
        // directed part
        set_entry(0, 1'b1, make_pix(20, 100, 140, 120, 200, 1'b0),
                  make_pix(20, 100, 110, 150, 200, 1'b0));
        set_entry(1, 1'b1, make_pix(30, 50, 90, 50, 500, 1'b0),
                  make_pix(30, 50, 50, 90, 500, 1'b0));
        set_entry(2, 1'b0, make_pix(1, 1, 1, 1, 1, 1'b0), make_pix(2, 2, 2, 2, 2, 1'b0));
        // degenerate fits
        set_entry(3, 1'b1, make_pix(10, 100, 90, 200, 300, 1'b0),
                  make_pix(10, 100, 300, 50, 300, 1'b0));
        set_entry(4, 1'b1, make_pix(12, 77, 77, 77, 200, 1'b0),
                  make_pix(5, 0, 0, 0, 1, 1'b0));
        // saturation at both ends of the disparity range
        set_entry(5, 1'b1, make_pix(0, 10, 10, 60, 100, 1'b0),
                  make_pix(63, 10, 60, 10, 100, 1'b0));
        set_entry(6, 1'b0, make_pix(3, 3, 3, 3, 3, 1'b1), make_pix(4, 4, 4, 4, 4, 1'b1));
        set_entry(7, 1'b0, make_pix(5, 5, 5, 5, 5, 1'b0), make_pix(6, 6, 6, 6, 6, 1'b0));
        // uniqueness boundary, 125 fails and 126 passes
        set_entry(8, 1'b1, make_pix(40, 100, 200, 200, 125, 1'b0),
                  make_pix(40, 100, 200, 200, 126, 1'b0));
        set_entry(9, 1'b1, make_pix(8, 100, 180, 130, 400, 1'b1),
                  make_pix(8, 100, 130, 180, 110, 1'b0));
        set_entry(10, 1'b1, make_pix(50, 0, 0, 0, 0, 1'b1),
                  make_pix(50, 1000, 1500, 1200, 5000, 1'b0));
        set_entry(11, 1'b1, make_pix(62, 60000, 65535, 62000, 65535, 1'b0),
                  make_pix(1, 60000, 62000, 65535, 65535, 1'b1));
        set_entry(12, 1'b1, make_pix(17, 300, 340, 330, 900, 1'b0),
                  make_pix(44, 250, 251, 400, 600, 1'b0));
        set_entry(13, 1'b1, make_pix(33, 1234, 2000, 1300, 1600, 1'b0),
                  make_pix(34, 999, 1100, 1100, 1300, 1'b1));
        for (int i = NUM_HAND; i < NUM_ENTRIES; i++) begin
            set_entry(i, ($urandom % 4) != 0, random_pix(), random_pix());
        end
    endtask

    task automatic check_output_beat();
        exp_beat_t head;
        if (exp_q.size() == 0) begin
            fail_run($sformatf("out_valid high at cycle %0d with no beat expected", cycle_cnt));
        end else if (exp_q[0].due != cycle_cnt) begin
            fail_run($sformatf("beat arrived at cycle %0d but was due at cycle %0d",
                               cycle_cnt, exp_q[0].due));
        end else begin
            head = exp_q.pop_front();
            for (int l = 0; l < LANES; l++) begin
                check_disp($sformatf("pix_out[%0d].frac_disp", l), pix_out[l].frac_disp,
                           head.px[l].frac_disp);
                check_sad($sformatf("pix_out[%0d].sad", l), pix_out[l].sad, head.px[l].sad);
                check_flag($sformatf("pix_out[%0d].filtered", l), pix_out[l].filtered,
                           head.px[l].filtered);
            end
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            fail_run($sformatf("timeout after %0d cycles, outputs stopped arriving", cycle_cnt));
        end
    end

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            if (out_valid !== 1'b0) begin
                fail_run("out_valid was not low while reset was held");
            end
        end else if (out_valid === 1'b1) begin
            check_output_beat();
        end else if (out_valid !== 1'b0) begin
            fail_run("out_valid is unknown after reset");
        end else if (exp_q.size() != 0 && exp_q[0].due <= cycle_cnt) begin
            fail_run($sformatf("expected beat missing at cycle %0d", cycle_cnt));
        end
    end

    initial begin
        void'($urandom(32'h7a8b));
        rst_n    = 1'b0;
        in_valid = 1'b0;
        pix_in   = '0;
        fill_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            @(posedge clk);
            #1;
            in_valid = tab[i].valid;
            pix_in   = tab[i].px;
            // the input register is the first of the L stages
            if (tab[i].valid) begin
                exp_q.push_back('{due: cycle_cnt + L, px: tab[i].exp});
            end
        end
        @(posedge clk);
        #1 in_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        // quiet tail, stray beats would be caught here
        repeat (L + 2) @(posedge clk);
        if (exp_q.size() != 0) begin
            fail_run($sformatf("%0d expected beats never came out", exp_q.size()));
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: src/stereo_postprocess.sv
`default_nettype none

module stereo_postprocess #(
    parameter int MULT_R     = 2,
    parameter int SUB_BITS   = 4,
    parameter int UNIQUE_MUL = 1,
    parameter int UNIQUE_DIV = 4
) (
    input  wire                                        clk,
    input  wire                                        rst_n,
    input  wire                                        in_valid,
    input  wire stereo_types_pkg::pix_in_t [MULT_R-1:0] pix_in,
    output logic                                       out_valid,
    output stereo_types_pkg::pix_out_t [MULT_R-1:0]    pix_out
);

    localparam int SAD_BITS = stereo_types_pkg::SAD_BITS;
    // input reg, prep, SUB_BITS divide stages, assembly, output reg
    localparam int LATENCY  = SUB_BITS + 4;
    // from the input register up to the output register
    localparam int SIDE_DLY = SUB_BITS + 2;

    stereo_types_pkg::pix_in_t [MULT_R-1:0] pix_q;
    wire stereo_types_pkg::pix_out_t [MULT_R-1:0] beat_d;

    always_ff @(posedge clk) begin
        pix_q <= pix_in;
    end

    for (genvar l = 0; l < MULT_R; l++) begin : g_lane
        postproc_pipe_pkg::div_work_t work;
        stereo_types_pkg::frac_disp_t frac;
        logic                         unique_fail;
        logic [SAD_BITS:0]            side_in;
        logic [SAD_BITS:0]            side_out;

        subpixel_prep u_prep (
            .clk  (clk),
            .px   (pix_q[l]),
            .work (work)
        );

        subpixel_divide #(
            .SUB_BITS (SUB_BITS)
        ) u_divide (
            .clk       (clk),
            .work      (work),
            .frac_disp (frac)
        );

        uniqueness_check #(
            .SUB_BITS   (SUB_BITS),
            .UNIQUE_MUL (UNIQUE_MUL),
            .UNIQUE_DIV (UNIQUE_DIV)
        ) u_unique (
            .clk         (clk),
            .rst_n       (rst_n),
            .sad         (pix_q[l].sad),
            .thresh      (pix_q[l].thresh),
            .unique_fail (unique_fail)
        );

        // texture flag rides along with the winning sad
        assign side_in = {pix_q[l].textured, pix_q[l].sad};

        pipe_delay #(
            .WIDTH     (SAD_BITS + 1),
            .DELAY     (SIDE_DLY),
            .HAS_RESET (1'b0)
        ) u_side (
            .clk      (clk),
            .rst_n    (rst_n),
            .in_data  (side_in),
            .out_data (side_out)
        );

        assign beat_d[l].frac_disp = frac;
        assign beat_d[l].sad       = side_out[SAD_BITS-1:0];
        assign beat_d[l].filtered  = side_out[SAD_BITS] | unique_fail;
    end

    always_ff @(posedge clk) begin
        pix_out <= beat_d;
    end

    // only control state that sees reset
    pipe_delay #(
        .WIDTH     (1),
        .DELAY     (LATENCY),
        .HAS_RESET (1'b1)
    ) u_valid (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_data  (in_valid),
        .out_data (out_valid)
    );

endmodule

`default_nettype wire

// File: src/uniqueness_check.sv
`default_nettype none

module uniqueness_check #(
    parameter int SUB_BITS   = 4,
    parameter int UNIQUE_MUL = 1,
    parameter int UNIQUE_DIV = 4
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire stereo_types_pkg::sad_t sad,
    input  wire stereo_types_pkg::sad_t thresh,
    output logic                        unique_fail
);

    // winner scaled by (1 + MUL/DIV), both sides multiplied through by DIV
    localparam int SAD_SCALE = UNIQUE_MUL + UNIQUE_DIV;
    localparam int PROD_W    = stereo_types_pkg::SAD_BITS + $clog2(SAD_SCALE + 1);

    logic [PROD_W-1:0] sad_prod_q;
    logic [PROD_W-1:0] thr_prod_q;
    logic              fail_q;

    always_ff @(posedge clk) begin
        sad_prod_q <= PROD_W'(sad) * PROD_W'(SAD_SCALE);
        thr_prod_q <= PROD_W'(thresh) * PROD_W'(UNIQUE_DIV);
    end

    // rival has to be strictly worse than the margin
    always_ff @(posedge clk) begin
        fail_q <= !(thr_prod_q > sad_prod_q);
    end

    // line up with prep plus divider
    pipe_delay #(
        .WIDTH     (1),
        .DELAY     (SUB_BITS),
        .HAS_RESET (1'b0)
    ) u_align (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_data  (fail_q),
        .out_data (unique_fail)
    );

endmodule

`default_nettype wire

// File: src/subpixel_divide.sv
`default_nettype none

module subpixel_divide #(
    parameter int SUB_BITS = 4
) (
    input  wire                                clk,
    input  wire postproc_pipe_pkg::div_work_t  work,
    output stereo_types_pkg::frac_disp_t       frac_disp
);

    localparam int REM_BITS = postproc_pipe_pkg::REM_BITS;
    localparam int QUO_BITS = postproc_pipe_pkg::QUO_BITS;
    localparam int FIX_W    = stereo_types_pkg::DISP_BITS + SUB_BITS;
    // a parabola fit never moves more than half a pixel
    localparam int Q_MAX    = 2 ** (SUB_BITS - 1);

    postproc_pipe_pkg::div_work_t stage_q [SUB_BITS];

    // one quotient bit per stage
    for (genvar i = 0; i < SUB_BITS; i++) begin : g_stage
        postproc_pipe_pkg::div_work_t cur;
        postproc_pipe_pkg::div_work_t nxt;
        postproc_pipe_pkg::rem_t      rem_x2;
        postproc_pipe_pkg::rem_t      den_ext;

        if (i == 0) begin : g_first
            assign cur = work;
        end else begin : g_next
            assign cur = stage_q[i-1];
        end

        assign den_ext = postproc_pipe_pkg::rem_t'(cur.den);

        always_comb begin
            rem_x2 = {cur.rem[REM_BITS-2:0], 1'b0};
            nxt    = cur;
            if (rem_x2 >= den_ext) begin
                nxt.rem = rem_x2 - den_ext;
                nxt.quo = {cur.quo[QUO_BITS-2:0], 1'b1};
            end else begin
                nxt.rem = rem_x2;
                nxt.quo = {cur.quo[QUO_BITS-2:0], 1'b0};
            end
        end

        always_ff @(posedge clk) begin
            stage_q[i] <= nxt;
        end
    end

    // assembly stage
    postproc_pipe_pkg::div_work_t last;
    logic [SUB_BITS-1:0]          q_raw;
    logic [SUB_BITS-1:0]          q_lim;
    logic [FIX_W:0]               base;
    logic [FIX_W:0]               offs;
    logic [FIX_W:0]               acc;
    logic [FIX_W-1:0]             fix_val;

    assign last = stage_q[SUB_BITS-1];

    always_comb begin
        q_raw = last.quo[SUB_BITS-1:0];
        if (last.degen) begin
            q_lim = '0;
        end else if (q_raw > SUB_BITS'(Q_MAX)) begin
            q_lim = SUB_BITS'(Q_MAX);
        end else begin
            q_lim = q_raw;
        end

        base = {1'b0, last.disp, {SUB_BITS{1'b0}}};
        offs = (FIX_W + 1)'(q_lim);

        // extra top bit catches borrow or carry for saturation
        if (last.neg) begin
            acc     = base - offs;
            fix_val = acc[FIX_W] ? '0 : acc[FIX_W-1:0];
        end else begin
            acc     = base + offs;
            fix_val = acc[FIX_W] ? '1 : acc[FIX_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        frac_disp <= stereo_types_pkg::frac_disp_t'(fix_val);
    end

endmodule

`default_nettype wire

// File: src/subpixel_prep.sv
`default_nettype none

module subpixel_prep (
    input  wire                           clk,
    input  wire stereo_types_pkg::pix_in_t px,
    output postproc_pipe_pkg::div_work_t  work
);

    localparam int SAD_BITS = stereo_types_pkg::SAD_BITS;
    localparam int DEN_BITS = postproc_pipe_pkg::DEN_BITS;

    stereo_types_pkg::sad_t       num;
    // lo+hi-2*sad, exact whenever lo and hi are not below sad
    logic [DEN_BITS-1:0]          span;
    postproc_pipe_pkg::den_t      den;
    logic                         den_zero;
    logic                         below;
    postproc_pipe_pkg::div_work_t work_d;

    always_comb begin
        // numerator |lo-hi|
        if (px.lo > px.hi) begin
            num = px.lo - px.hi;
        end else begin
            num = px.hi - px.lo;
        end

        span = {2'b00, px.lo} + {2'b00, px.hi} - {1'b0, px.sad, 1'b0};
        den  = {span[SAD_BITS:0], 1'b0};

        den_zero = (den == '0);
        // winner is not a true local minimum
        below    = (px.lo < px.sad) || (px.hi < px.sad);

        work_d.rem   = postproc_pipe_pkg::rem_t'(num);
        work_d.den   = den;
        work_d.quo   = '0;
        // offset goes negative unless lo is the larger neighbour
        work_d.neg   = (px.lo <= px.hi);
        work_d.degen = below || den_zero;
        work_d.disp  = px.disp;
    end

    always_ff @(posedge clk) begin
        work <= work_d;
    end

endmodule

`default_nettype wire

// File: src/pipe_delay.sv
`default_nettype none

module pipe_delay #(
    parameter int WIDTH     = 1,
    parameter int DELAY     = 1,
    parameter bit HAS_RESET = 1'b0
) (
    input  wire              clk,
    input  wire              rst_n,
    input  wire [WIDTH-1:0]  in_data,
    output logic [WIDTH-1:0] out_data
);

    logic [WIDTH-1:0] chain_q [DELAY];

    generate
        if (HAS_RESET) begin : g_rst
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int i = 0; i < DELAY; i++) begin
                        chain_q[i] <= '0;
                    end
                end else begin
                    chain_q[0] <= in_data;
                    for (int i = 1; i < DELAY; i++) begin
                        chain_q[i] <= chain_q[i-1];
                    end
                end
            end
        end else begin : g_no_rst
            // plain shift register, contents undefined after reset
            always_ff @(posedge clk) begin
                chain_q[0] <= in_data;
                for (int i = 1; i < DELAY; i++) begin
                    chain_q[i] <= chain_q[i-1];
                end
            end
        end
    endgenerate

    assign out_data = chain_q[DELAY-1];

endmodule

`default_nettype wire

// File: src/postproc_pipe_pkg.sv
`default_nettype none

package postproc_pipe_pkg;

    // remainder needs headroom for the doubling step
    localparam int REM_BITS = stereo_types_pkg::SAD_BITS + 3;
    // divisor is 2*(lo+hi-2*sad)
    localparam int DEN_BITS = stereo_types_pkg::SAD_BITS + 2;
    localparam int QUO_BITS = stereo_types_pkg::SUB_MAX + 1;

    typedef logic [REM_BITS-1:0] rem_t;
    typedef logic [DEN_BITS-1:0] den_t;
    typedef logic [QUO_BITS-1:0] quo_t;

    // state carried from one divider stage to the next
    typedef struct packed {
        // partial remainder, starts as |lo-hi|
        rem_t                    rem;
        den_t                    den;
        // fraction bits collected so far, newest in bit 0
        quo_t                    quo;
        // offset points toward disparity-1
        logic                    neg;
        // fit unusable, offset forced to zero
        logic                    degen;
        stereo_types_pkg::disp_t disp;
    } div_work_t;

endpackage

`default_nettype wire

// File: src/stereo_types_pkg.sv
`default_nettype none

package stereo_types_pkg;

    // integer disparity, 0 to 63
    localparam int DISP_BITS = 6;
    localparam int SAD_BITS  = 16;
    // widest fraction the fixed-point disparity can hold
    localparam int SUB_MAX   = 6;

    typedef logic [DISP_BITS-1:0]         disp_t;
    typedef logic [SAD_BITS-1:0]          sad_t;
    // right-aligned, upper bits zero when fewer fraction bits are built
    typedef logic [DISP_BITS+SUB_MAX-1:0] frac_disp_t;

    // one pixel of an input beat
    typedef struct packed {
        disp_t disp;
        sad_t  sad;
        sad_t  lo;
        sad_t  hi;
        sad_t  thresh;
        logic  textured;
    } pix_in_t;

    // one pixel of an output beat
    typedef struct packed {
        frac_disp_t frac_disp;
        sad_t       sad;
        logic       filtered;
    } pix_out_t;

endpackage

`default_nettype wire
